//--- fetch.f
rtl/fetchPkg.sv
rtl/instrMem.sv
rtl/loadControl.sv
rtl/pcUnit.sv
rtl/fetchTop.sv
test/fetchChecker.sv
test/fetchTb.sv

//--- Bender.yml
package:
  name: fetch

sources:
  - rtl/fetchPkg.sv
  - rtl/instrMem.sv
  - rtl/loadControl.sv
  - rtl/pcUnit.sv
  - rtl/fetchTop.sv
  - target: test
    files:
      - test/fetchChecker.sv
      - test/fetchTb.sv

//--- test/fetchTb.sv
`timescale 1ns/1ns

module fetchTb;

  import fetchPkg::*;

  localparam int MemBits   = 6;           // Short memory for the run
  localparam int Depth     = 2**MemBits;
  localparam int ExtraWr   = 40;          // Random writes after the sweep
  localparam int RunCycles = 400;
  localparam int WaitLimit = 200;         // Cycles before a wait gives up

  logic        Jal;
  logic        reset;
  branchCtrl_t ctrl;
  word_t       branchTarget;
  word_t       regAddr;
  logic        inited;
  logic        upgReset;
  logic        upgDone;
  upgWrite_t   upg;
  word_t       instruction;
  word_t       branchBase;
  word_t       linkAddr;
  int          errorCount;
  int          checkCount;
  logic [31:0] rngState;
  logic        timedOut;

  fetchTop #(.AddrBits(MemBits)) u_fetchTop (
    .Jal            (Jal),
    .reset          (reset),
    .ctrl_i         (ctrl),
    .branchTarget_i (branchTarget),
    .regAddr_i      (regAddr),
    .inited_i       (inited),
    .upgReset_i     (upgReset),
    .upgDone_i      (upgDone),
    .upg_i          (upg),
    .instruction_o  (instruction),
    .branchBase_o   (branchBase),
    .linkAddr_o     (linkAddr)
  );

  fetchChecker #(.AddrBits(MemBits)) outputCheck (
    .Jal            (Jal),
    .reset          (reset),
    .ctrl_i         (ctrl),
    .branchTarget_i (branchTarget),
    .regAddr_i      (regAddr),
    .inited_i       (inited),
    .upgReset_i     (upgReset),
    .upgDone_i      (upgDone),
    .upg_i          (upg),
    .instruction_i  (instruction),
    .branchBase_i   (branchBase),
    .linkAddr_i     (linkAddr),
    .errorCount_o   (errorCount),
    .checkCount_o   (checkCount)
  );

  initial begin
    Jal = 1'b0;
    forever #5 Jal = ~Jal;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic drawRand(output logic [31:0] value);
    rngState = xorshift32(rngState);
    value    = rngState;
  endtask

  // Half the words carry a jump field that stays inside memory
  task automatic drawWord(output word_t value);
    logic [31:0] r;
    drawRand(r);
    value = r[31] ? {r[31:26], 20'b0, r[5:0]} : r;
  endtask

  task automatic loadProgram();
    logic [31:0] r;
    word_t       data;
    for (int i = 0; i < Depth; i++) begin    // Every word once
      drawRand(r);
      drawWord(data);
      @(negedge Jal);
      upg.wen                  = 1'b1;
      upg.addr                 = upgAddr_t'(r);
      upg.addr[14]             = 1'b0;
      upg.addr[MemBits-1:0]    = MemBits'(i);
      upg.data                 = data;
    end
    for (int i = 0; i < ExtraWr; i++) begin  // Overwrites, top bit random
      drawRand(r);
      drawWord(data);
      @(negedge Jal);
      upg.wen  = r[20];                      // Some idle cycles too
      upg.addr = upgAddr_t'(r);
      upg.data = data;
    end
    @(negedge Jal);
    upg = '0;
  endtask

  // Sequential walk up to the last word, then a few held cycles
  task automatic walkSequence();
    logic found;
    found = 1'b0;
    for (int n = 0; n < WaitLimit && !found; n++) begin
      @(negedge Jal);
      found = (branchBase == word_t'(Depth * 4));
    end
    if (!found) begin
      $display("fetchTb: PC never reached the last memory word");
      timedOut = 1'b1;
    end
    repeat (5) @(negedge Jal);
  endtask

  task automatic randomControl();
    logic [31:0] r;
    logic [31:0] s;
    for (int n = 0; n < RunCycles; n++) begin
      drawRand(r);
      drawRand(s);
      @(negedge Jal);
      ctrl      = '0;
      ctrl.zero = r[3];
      case (r[2:0])
        3'd0: ctrl.branch   = 1'b1;
        3'd1: ctrl.nBranch  = 1'b1;
        3'd2: ctrl.jump     = 1'b1;
        3'd3: ctrl.jumpLink = 1'b1;
        3'd4: ctrl.jumpReg  = 1'b1;
        3'd5: begin                           // jr wins over a taken beq
          ctrl.jumpReg = 1'b1;
          ctrl.branch  = 1'b1;
          ctrl.zero    = 1'b1;
        end
        default: ;                            // Plain PC+4
      endcase
      branchTarget = word_t'(r[23:8] % Depth) << 2;
      regAddr      = word_t'(s[23:8] % Depth) << 2;
      upg.wen      = s[31];                   // Must be ignored in run mode
      upg.addr     = upgAddr_t'(s[30:16]);
      upg.data     = r;
    end
    @(negedge Jal);
    ctrl = '0;
    upg  = '0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main flow
  //////////////////////////////////////////////////////////////////////

  initial begin
    rngState     = 32'hdcb3b1db;
    timedOut     = 1'b0;
    reset        = 1'b1;
    ctrl         = '0;
    branchTarget = '0;
    regAddr      = '0;
    inited       = 1'b0;
    upgReset     = 1'b0;
    upgDone      = 1'b0;
    upg          = '0;
    repeat (8) @(negedge Jal);
    reset = 1'b0;
    loadProgram();                            // Load mode, PC parked at 0
    @(negedge Jal);
    upgDone = 1'b1;
    inited  = 1'b1;
    walkSequence();
    if (!timedOut) begin
      randomControl();
    end
    repeat (4) @(negedge Jal);
    $display("fetchTb: %0d checks, %0d errors, timeout %0d", checkCount, errorCount, timedOut);
    if (errorCount == 0 && !timedOut) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- test/fetchChecker.sv
`timescale 1ns/1ns

module fetchChecker #(
  parameter int AddrBits = 14
) (
  input  logic                  Jal,
  input  logic                  reset,
  input  fetchPkg::branchCtrl_t ctrl_i,
  input  fetchPkg::word_t       branchTarget_i,
  input  fetchPkg::word_t       regAddr_i,
  input  logic                  inited_i,
  input  logic                  upgReset_i,
  input  logic                  upgDone_i,
  input  fetchPkg::upgWrite_t   upg_i,
  input  fetchPkg::word_t       instruction_i,  // DUT outputs from here on
  input  fetchPkg::word_t       branchBase_i,
  input  fetchPkg::word_t       linkAddr_i,
  output int                    errorCount_o,
  output int                    checkCount_o
);

  import fetchPkg::*;

  localparam int Depth = 2**AddrBits;

  word_t modelMem   [Depth];
  logic  modelValid [Depth];   // Word written at least once
  word_t modelPc;
  word_t modelLink;
  int    errors;
  int    checks;

  assign errorCount_o = errors;
  assign checkCount_o = checks;

  initial begin
    errors = 0;
    checks = 0;
    for (int i = 0; i < Depth; i++) begin
      modelValid[i] = 1'b0;
    end
  end

  task automatic compareWord(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s: expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare on the rising edge, then step the model
  //////////////////////////////////////////////////////////////////////

  always @(posedge Jal or posedge reset) begin : modelStep
    logic                runMode;
    logic                taken;
    logic [AddrBits-1:0] idx;
    word_t               expInstr;
    word_t               nextPc;
    if (reset) begin
      modelPc   = '0;
      modelLink = '0;
    end else begin
      runMode  = upgReset_i || upgDone_i;
      idx      = modelPc[AddrBits+1:2];
      expInstr = runMode ? modelMem[idx] : '0;   // Zero while loading
      compareWord("branchBase", modelPc + 32'd4, branchBase_i);
      compareWord("linkAddr", modelLink, linkAddr_i);
      if (!runMode) begin
        compareWord("gating", '0, instruction_i);
      end else if (modelValid[idx]) begin
        compareWord("fetch", expInstr, instruction_i);
      end
      // beq on zero, bne on nonzero
      taken = (ctrl_i.branch && ctrl_i.zero) || (ctrl_i.nBranch && !ctrl_i.zero);
      if (!inited_i || !runMode) begin
        nextPc = '0;
      end else if (ctrl_i.jump || ctrl_i.jumpLink) begin
        nextPc = {4'b0000, expInstr[25:0], 2'b00};
      end else if (ctrl_i.jumpReg) begin
        nextPc = regAddr_i;
      end else if (taken) begin
        nextPc = branchTarget_i;
      end else if (modelPc[31:2] >= 30'(Depth - 1)) begin
        nextPc = modelPc;                         // Parked on the last word
      end else begin
        nextPc = modelPc + 32'd4;
      end
      if (ctrl_i.jumpLink) begin
        modelLink = modelPc + 32'd4;              // Return address
      end
      // Only load-mode writes to the low region land
      if (upg_i.wen && !runMode && !upg_i.addr[14]) begin
        modelMem[upg_i.addr[AddrBits-1:0]]   = upg_i.data;
        modelValid[upg_i.addr[AddrBits-1:0]] = 1'b1;
      end
      modelPc = nextPc;
    end
  end

endmodule

//--- rtl/fetchTop.sv
`timescale 1ns/1ns

module fetchTop #(
  parameter int AddrBits = 14        // Instruction memory word address width
) (
  input  logic                  Jal,             // System clock
  input  logic                  reset,
  input  fetchPkg::branchCtrl_t ctrl_i,          // Decoder and ALU strobes
  input  fetchPkg::word_t       branchTarget_i,
  input  fetchPkg::word_t       regAddr_i,
  input  logic                  inited_i,
  input  logic                  upgReset_i,
  input  logic                  upgDone_i,
  input  fetchPkg::upgWrite_t   upg_i,
  output fetchPkg::word_t       instruction_o,
  output fetchPkg::word_t       branchBase_o,
  output fetchPkg::word_t       linkAddr_o
);

  import fetchPkg::*;

  logic                runMode;
  upgWrite_t           memWrite;   // Filtered programmer write
  word_t               rawInstr;   // Ungated memory word
  logic [AddrBits-1:0] memAddr;    // PC word index

  //////////////////////////////////////////////////////////////////////
  // Loader, memory, PC
  //////////////////////////////////////////////////////////////////////

  loadControl u_loadControl (
    .upgReset_i    (upgReset_i),
    .upgDone_i     (upgDone_i),
    .upg_i         (upg_i),
    .rawInstr_i    (rawInstr),
    .runMode_o     (runMode),
    .memWrite_o    (memWrite),
    .instruction_o (instruction_o)
  );

  instrMem #(.AddrBits(AddrBits)) u_instrMem (
    .Jal        (Jal),
    .write_i    (memWrite),
    .readAddr_i (memAddr),
    .data_o     (rawInstr)
  );

  pcUnit #(.AddrBits(AddrBits)) u_pcUnit (
    .Jal            (Jal),
    .reset          (reset),
    .inited_i       (inited_i),
    .runMode_i      (runMode),
    .ctrl_i         (ctrl_i),
    .instruction_i  (instruction_o),   // Gated word, zero while loading
    .branchTarget_i (branchTarget_i),
    .regAddr_i      (regAddr_i),
    .memAddr_o      (memAddr),
    .branchBase_o   (branchBase_o),
    .linkAddr_o     (linkAddr_o)
  );

endmodule

//--- rtl/pcUnit.sv
`timescale 1ns/1ns

module pcUnit #(
  parameter int AddrBits = 14
) (
  input  logic                  Jal,             // System clock
  input  logic                  reset,
  input  logic                  inited_i,
  input  logic                  runMode_i,
  input  fetchPkg::branchCtrl_t ctrl_i,
  input  fetchPkg::word_t       instruction_i,   // Already gated by mode
  input  fetchPkg::word_t       branchTarget_i,  // From ALU
  input  fetchPkg::word_t       regAddr_i,       // Register value for jr
  output logic [AddrBits-1:0]   memAddr_o,
  output fetchPkg::word_t       branchBase_o,
  output fetchPkg::word_t       linkAddr_o
);

  import fetchPkg::*;

  // Word index of the last memory entry
  localparam logic [WordBits-3:0] LastIndex = (WordBits-2)'(2**AddrBits - 1);

  word_t pc;
  word_t pcNext;
  word_t pcPlus4;
  word_t jumpTarget;
  logic  running;      // Processor allowed to fetch
  logic  jumpAbs;      // j or jal
  logic  takeBranch;   // Branch condition met
  logic  atLastWord;   // Sequential fetch would run off the memory
  logic  loadBranch;   // PC picks the branch target this edge

  //////////////////////////////////////////////////////////////////////
  // Next PC
  //////////////////////////////////////////////////////////////////////

  assign pcPlus4    = pc + word_t'(4);
  assign jumpTarget = {4'b0000, instruction_i[JumpFieldBits-1:0], 2'b00};

  assign running    = inited_i && runMode_i;
  assign jumpAbs    = ctrl_i.jump || ctrl_i.jumpLink;
  assign takeBranch = (ctrl_i.branch && ctrl_i.zero) ||
                      (ctrl_i.nBranch && !ctrl_i.zero);
  assign atLastWord = pc[WordBits-1:2] >= LastIndex;

  // Priority order matters here
  always_comb begin
    if (!running) begin
      pcNext = '0;              // Held at 0 until programmed and inited
    end else if (jumpAbs) begin
      pcNext = jumpTarget;
    end else if (ctrl_i.jumpReg) begin
      pcNext = regAddr_i;
    end else if (takeBranch) begin
      pcNext = branchTarget_i;
    end else if (atLastWord) begin
      pcNext = pc;              // Park on the last word
    end else begin
      pcNext = pcPlus4;
    end
  end

  assign loadBranch = running && !jumpAbs && !ctrl_i.jumpReg && takeBranch;

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Jal or posedge reset) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

  // Return address of jal, held until the next one
  always_ff @(posedge Jal or posedge reset) begin
    if (reset) begin
      linkAddr_o <= '0;
    end else if (ctrl_i.jumpLink) begin
      linkAddr_o <= pcPlus4;
    end
  end

  assign memAddr_o    = pc[AddrBits+1:2];  // Byte address to word index
  assign branchBase_o = pcPlus4;           // ALU adds the offset to this

  // Decoder never raises two jump kinds at once
  jumpOneHot: assert property (@(posedge Jal) disable iff (reset)
    $onehot0({ctrl_i.jump, ctrl_i.jumpLink, ctrl_i.jumpReg}))
    else $error("pcUnit: more than one jump strobe");

  // A taken branch only ever loads an aligned target
  branchAligned: assert property (@(posedge Jal) disable iff (reset)
    loadBranch |-> (branchTarget_i[1:0] == 2'b00))
    else $error("pcUnit: branch target not word aligned");

endmodule

//--- rtl/loadControl.sv
`timescale 1ns/1ns

module loadControl (
  input  logic                upgReset_i,     // Programmer held in reset
  input  logic                upgDone_i,      // Programmer finished loading
  input  fetchPkg::upgWrite_t upg_i,          // Raw programmer write
  input  fetchPkg::word_t     rawInstr_i,     // Word read from memory
  output logic                runMode_o,      // High while the processor runs
  output fetchPkg::upgWrite_t memWrite_o,     // Write passed to memory
  output fetchPkg::word_t     instruction_o   // Fetched instruction
);

  import fetchPkg::*;

  logic inRegion;   // Address targets instruction memory
  logic loadMode;

  //////////////////////////////////////////////////////////////////////
  // Mode
  //////////////////////////////////////////////////////////////////////

  // Programmer in reset means nothing is loading, so run
  // Programmer done means the image is in place, so run too
  assign runMode_o = upgReset_i || upgDone_i;
  assign loadMode  = !runMode_o;

  //////////////////////////////////////////////////////////////////////
  // Write filter
  //////////////////////////////////////////////////////////////////////

  assign inRegion = !upg_i.addr[RegionBit];

  always_comb begin
    memWrite_o     = upg_i;                            // Address and data pass as is
    memWrite_o.wen = upg_i.wen && inRegion && loadMode;
  end

  //////////////////////////////////////////////////////////////////////
  // Instruction gate
  //////////////////////////////////////////////////////////////////////

  // Decoder sees a nop-like zero while loading
  assign instruction_o = runMode_o ? rawInstr_i : '0;

  // Writes reach memory only in load mode and only for its region
  loadOnlyWrite: assert final (!memWrite_o.wen ||
                               (loadMode && !memWrite_o.addr[RegionBit]))
    else $error("loadControl: write forwarded in run mode");

endmodule

//--- rtl/instrMem.sv
`timescale 1ns/1ns

module instrMem #(
  parameter int AddrBits = 14
) (
  input  logic                 Jal,         // System clock, also the write clock
  input  fetchPkg::upgWrite_t  write_i,     // Filtered programmer write
  input  logic [AddrBits-1:0]  readAddr_i,  // Word index from the PC
  output fetchPkg::word_t      data_o
);

  import fetchPkg::*;

  localparam int Depth = 2**AddrBits;

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  word_t               mem [Depth];
  logic [AddrBits-1:0] writeIdx;

  // Low bits of the programmer address pick the word
  assign writeIdx = write_i.addr[AddrBits-1:0];

  // Write lands at the edge
  always_ff @(posedge Jal) begin
    if (write_i.wen) begin
      mem[writeIdx] <= write_i.data;
    end
  end

  // Asynchronous read
  // Same-cycle read of a written address still sees the old word
  assign data_o = mem[readAddr_i];

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Loader only passes writes aimed at instruction memory
  regionOnly: assert property (@(posedge Jal)
    write_i.wen |-> !write_i.addr[RegionBit])
    else $error("instrMem: write outside the instruction region");

endmodule

//--- rtl/fetchPkg.sv
package fetchPkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int WordBits      = 32;
  localparam int UpgAddrBits   = 15;               // Programmer word address
  localparam int RegionBit     = UpgAddrBits - 1;  // High means not instruction memory
  localparam int JumpFieldBits = 26;               // Target field of j / jal

  // Instruction, address or data word
  typedef logic [WordBits-1:0] word_t;

  // Programmer word address, top bit picks the region
  typedef logic [UpgAddrBits-1:0] upgAddr_t;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////

  // Decoder and ALU strobes for the current instruction
  typedef struct packed {
    logic branch;    // beq
    logic nBranch;   // bne
    logic jump;      // j
    logic jumpLink;  // jal
    logic jumpReg;   // jr
    logic zero;      // ALU result is zero
  } branchCtrl_t;

  // One programmer write
  typedef struct packed {
    logic     wen;
    upgAddr_t addr;
    word_t    data;
  } upgWrite_t;

endpackage
